// ==== dummy_params.svh ====
// Dummy-instruction insertion parameters
// Widths, LFSR feedback taps, LFSR reload values and RV32 encodings
`ifndef DUMMY_PARAMS_SVH
`define DUMMY_PARAMS_SVH

`define XLEN 32
`define CNT_W 64

// Feedback taps at bits 31, 21, 1 and 0
`define LFSR_TAPS 32'h8020_0003

// Nonzero reload values used at reset and on lockup
`define LFSR0_DEFAULT 32'hA5C3_1E69
`define LFSR1_DEFAULT 32'h3F2B_9D47
`define LFSR2_DEFAULT 32'h6E18_C0B5

`define OPCODE_OP 7'b0110011
`define OPCODE_BRANCH 7'b1100011

`define FUNCT3_ADD 3'b000
`define FUNCT3_AND 3'b111
`define FUNCT3_MUL 3'b000
`define FUNCT3_BLTU 3'b110

`define FUNCT7_ADD 7'b0000000
`define FUNCT7_AND 7'b0000000
`define FUNCT7_MUL 7'b0000001

`endif

// ==== dummy_pkg.sv ====
// Dummy-instruction insertion types
// Shared vector types and the dummy operation encoding

`include "dummy_params.svh"

package dummy_pkg;

  typedef logic [`XLEN-1:0] instr_t;
  typedef logic [`XLEN-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // Frequency setting selects the upper bound on the dummy gap
  typedef logic [3:0] freq_t;
  typedef logic [6:0] gap_t;

  typedef logic [`CNT_W-1:0] counter_t;

  // Order matches the two select bits taken from LFSR0
  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_AND  = 2'd1,
    OP_MUL  = 2'd2,
    OP_BLTU = 2'd3
  } dummy_op_e;

endpackage

// ==== lfsr_state_if.sv ====
// LFSR state interface
// Carries the three LFSR values from the bank to the scheduler, encoder
// and ID stage, and the step strobes back from the ID stage

`timescale 1ns/1ps

interface lfsr_state_if;

  dummy_pkg::word_t lfsr0;
  dummy_pkg::word_t lfsr1;
  dummy_pkg::word_t lfsr2;

  // LFSR0 steps on a dummy load, LFSR1 and LFSR2 when a dummy leaves ID
  logic step0;
  logic step12;

  modport bank (output lfsr0, output lfsr1, output lfsr2, input step0, input step12);

  modport issue (input lfsr1, input lfsr2, output step0, output step12);

  modport sched (input lfsr0, input step0);

endinterface

// ==== dummy_lfsr.sv ====
// Seedable 32-bit Fibonacci LFSR
// A seed write wins over a step, and any zero result reloads RESET_VALUE
// so the register never locks up

`timescale 1ns/1ps
`include "dummy_params.svh"

module dummy_lfsr #(
  parameter dummy_pkg::word_t RESET_VALUE = `LFSR0_DEFAULT
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             step,
  input  logic             seed_we,
  input  dummy_pkg::word_t seed_wdata,
  output dummy_pkg::word_t value
);
  import dummy_pkg::*;

  word_t stepped;
  word_t value_d;

  assign stepped = {value[`XLEN-2:0], ^(value & `LFSR_TAPS)};

  always_comb begin
    value_d = value;
    if (seed_we) begin
      value_d = (seed_wdata == '0) ? RESET_VALUE : seed_wdata;
    end else if (step) begin
      value_d = (stepped == '0) ? RESET_VALUE : stepped;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      value <= RESET_VALUE;
    end else begin
      value <= value_d;
    end
  end

endmodule

// ==== lfsr_bank.sv ====
// LFSR bank
// Three seedable LFSRs with one-hot seed steering. LFSR0 drives scheduling
// and encoding, LFSR1 and LFSR2 supply the dummy operands

`timescale 1ns/1ps
`include "dummy_params.svh"

module lfsr_bank (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [2:0]         seed_we,
  input  dummy_pkg::word_t   seed_wdata,
  lfsr_state_if.bank         lfsr
);

  dummy_lfsr #(.RESET_VALUE(`LFSR0_DEFAULT)) lfsr0_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .step       (lfsr.step0),
    .seed_we    (seed_we[0]),
    .seed_wdata (seed_wdata),
    .value      (lfsr.lfsr0)
  );

  // The operand LFSRs advance together
  dummy_lfsr #(.RESET_VALUE(`LFSR1_DEFAULT)) lfsr1_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .step       (lfsr.step12),
    .seed_we    (seed_we[1]),
    .seed_wdata (seed_wdata),
    .value      (lfsr.lfsr1)
  );

  dummy_lfsr #(.RESET_VALUE(`LFSR2_DEFAULT)) lfsr2_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .step       (lfsr.step12),
    .seed_we    (seed_we[2]),
    .seed_wdata (seed_wdata),
    .value      (lfsr.lfsr2)
  );

endmodule

// ==== dummy_scheduler.sv ====
// Dummy scheduler
// Counts normal instructions accepted from fetch since the last dummy and
// raises dummy_due once the count reaches a random target below the bound

`timescale 1ns/1ps

module dummy_scheduler (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rnddummy_en,
  input  dummy_pkg::freq_t    dummy_freq,
  input  logic                fetch_accept,
  lfsr_state_if.sched         lfsr,
  output logic                dummy_due
);
  import dummy_pkg::*;

  gap_t bound;
  gap_t target;
  gap_t gap_cnt_q;

  // Bound is 4, 8, 16, 32 or 64 depending on the highest set setting bit
  always_comb begin
    if (dummy_freq[3]) begin
      bound = 7'd64;
    end else if (dummy_freq[2]) begin
      bound = 7'd32;
    end else if (dummy_freq[1]) begin
      bound = 7'd16;
    end else if (dummy_freq[0]) begin
      bound = 7'd8;
    end else begin
      bound = 7'd4;
    end
  end

  assign target = lfsr.lfsr0[6:0] & (bound - 7'd1);

  // A seed write may lower the target below the count, so compare with >=
  assign dummy_due = rnddummy_en && (gap_cnt_q >= target);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      gap_cnt_q <= '0;
    end else if (!rnddummy_en || lfsr.step0) begin
      gap_cnt_q <= '0;
    end else if (fetch_accept) begin
      gap_cnt_q <= gap_cnt_q + 7'd1;
    end
  end

endmodule

// ==== dummy_encoder.sv ====
// Dummy instruction encoder
// Builds an ADD, AND, MUL or BLTU word from LFSR0. The destination is
// always x0 and the branch form always has a zero offset

`timescale 1ns/1ps
`include "dummy_params.svh"

module dummy_encoder (
  lfsr_state_if.sched        lfsr,
  output dummy_pkg::instr_t  dummy_instr
);
  import dummy_pkg::*;

  dummy_op_e op;
  reg_addr_t rs1;
  reg_addr_t rs2;

  assign op  = dummy_op_e'(lfsr.lfsr0[31:30]);
  assign rs1 = lfsr.lfsr0[29:25];
  assign rs2 = lfsr.lfsr0[24:20];

  always_comb begin
    case (op)
      OP_ADD:  dummy_instr = {`FUNCT7_ADD, rs2, rs1, `FUNCT3_ADD, 5'd0, `OPCODE_OP};
      OP_AND:  dummy_instr = {`FUNCT7_AND, rs2, rs1, `FUNCT3_AND, 5'd0, `OPCODE_OP};
      OP_MUL:  dummy_instr = {`FUNCT7_MUL, rs2, rs1, `FUNCT3_MUL, 5'd0, `OPCODE_OP};
      // B-type with every immediate bit zero
      default: dummy_instr = {7'd0, rs2, rs1, `FUNCT3_BLTU, 5'd0, `OPCODE_BRANCH};
    endcase
  end

endmodule

// ==== id_issue_stage.sv ====
// ID issue stage
// Single ID register that merges dummy instructions into the fetched
// stream. Dummies take priority over fetch whenever the slot is free

`timescale 1ns/1ps

module id_issue_stage (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               if_valid,
  input  dummy_pkg::instr_t  if_instr,
  output logic               if_ready,
  input  logic               dummy_due,
  input  dummy_pkg::instr_t  dummy_instr,
  input  logic               id_ready,
  output logic               id_valid,
  output dummy_pkg::instr_t  id_instr,
  output logic               id_dummy,
  output dummy_pkg::word_t   operand_a,
  output dummy_pkg::word_t   operand_b,
  output logic               fetch_accept,
  output logic               retire_normal,
  lfsr_state_if.issue        lfsr
);

  logic slot_free;
  logic load_dummy;
  logic id_leave;

  assign slot_free    = !id_valid || id_ready;
  assign load_dummy   = slot_free && dummy_due;
  assign if_ready     = slot_free && !dummy_due;
  assign fetch_accept = if_valid && if_ready;
  assign id_leave     = id_valid && id_ready;

  assign retire_normal = id_leave && !id_dummy;
  assign lfsr.step0    = load_dummy;
  assign lfsr.step12   = id_leave && id_dummy;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      id_valid <= 1'b0;
      id_dummy <= 1'b0;
    end else if (slot_free) begin
      id_valid <= load_dummy || fetch_accept;
      id_dummy <= load_dummy;
    end
  end

  // Payload only changes on a load, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (load_dummy) begin
      id_instr  <= dummy_instr;
      operand_a <= lfsr.lfsr1;
      operand_b <= lfsr.lfsr2;
    end else if (fetch_accept) begin
      id_instr  <= if_instr;
      operand_a <= '0;
      operand_b <= '0;
    end
  end

endmodule

// ==== perf_counters.sv ====
// Performance counters
// mcycle counts every cycle after reset. minstret counts normal
// instructions leaving ID and skips dummies

`timescale 1ns/1ps

module perf_counters (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 retire_normal,
  output dummy_pkg::counter_t  mcycle,
  output dummy_pkg::counter_t  minstret
);
  import dummy_pkg::*;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mcycle <= '0;
    end else begin
      mcycle <= mcycle + counter_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      minstret <= '0;
    end else if (retire_normal) begin
      minstret <= minstret + counter_t'(1);
    end
  end

endmodule

// ==== dummy_insert_unit.sv ====
// Dummy-instruction insertion unit
// Sits between fetch and decode, inserting randomized dummy instructions
// at random gaps. Also holds mcycle and minstret

`timescale 1ns/1ps

module dummy_insert_unit (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rnddummy_en,
  input  dummy_pkg::freq_t     dummy_freq,
  input  logic [2:0]           seed_we,
  input  dummy_pkg::word_t     seed_wdata,
  input  logic                 if_valid,
  input  dummy_pkg::instr_t    if_instr,
  output logic                 if_ready,
  input  logic                 id_ready,
  output logic                 id_valid,
  output dummy_pkg::instr_t    id_instr,
  output logic                 id_dummy,
  output dummy_pkg::word_t     operand_a,
  output dummy_pkg::word_t     operand_b,
  output dummy_pkg::counter_t  mcycle,
  output dummy_pkg::counter_t  minstret
);
  import dummy_pkg::*;

  logic   dummy_due;
  logic   fetch_accept;
  logic   retire_normal;
  instr_t dummy_instr;

  lfsr_state_if lfsr_if ();

  lfsr_bank lfsr_bank_i (
    .clk_i, .rst_ni, .seed_we, .seed_wdata, .lfsr(lfsr_if.bank)
  );

  dummy_scheduler scheduler_i (
    .clk_i, .rst_ni, .rnddummy_en, .dummy_freq, .fetch_accept,
    .lfsr(lfsr_if.sched), .dummy_due
  );

  dummy_encoder encoder_i (.lfsr(lfsr_if.sched), .dummy_instr);

  id_issue_stage issue_i (
    .clk_i, .rst_ni, .if_valid, .if_instr, .if_ready, .dummy_due, .dummy_instr,
    .id_ready, .id_valid, .id_instr, .id_dummy, .operand_a, .operand_b,
    .fetch_accept, .retire_normal, .lfsr(lfsr_if.issue)
  );

  perf_counters counters_i (.clk_i, .rst_ni, .retire_normal, .mcycle, .minstret);

endmodule

// ==== dummy_insert_sva.sv ====
// Assertions for the dummy-instruction insertion unit
// Bound to the top level, they watch dummy insertion, the ID hold
// behavior and the destination of every dummy

`timescale 1ns/1ps

module dummy_insert_sva (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              dummy_due,
  input logic              id_valid,
  input logic              id_ready,
  input logic              id_dummy,
  input dummy_pkg::instr_t id_instr
);

  // A due dummy takes the free slot at the next edge
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   dummy_due && (!id_valid || id_ready) |=> id_valid && id_dummy)
    else $error("due dummy did not enter a free ID slot");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   id_valid && !id_ready |=> $stable(id_instr))
    else $error("id_instr changed under back-pressure");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   id_valid && id_dummy |-> id_instr[11:7] == 5'd0)
    else $error("dummy instruction with rd other than x0");

endmodule

bind dummy_insert_unit dummy_insert_sva sva_i (
  .clk_i(clk_i), .rst_ni(rst_ni), .dummy_due(dummy_due),
  .id_valid(id_valid), .id_ready(id_ready), .id_dummy(id_dummy), .id_instr(id_instr)
);

// ==== tb_dummy_insert.sv ====
// Testbench for the dummy-instruction insertion unit
// Drives random fetch traffic, back-pressure and seed writes, and checks
// every ID output and both counters against a cycle model of the unit

`timescale 1ns/1ps
`include "dummy_params.svh"

module tb_dummy_insert;
  import dummy_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int EN_START = 300;
  localparam int PHASE_LEN = 400;
  localparam int TOTAL_CYCLES = EN_START + 6 * PHASE_LEN;
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + TOTAL_CYCLES);

  logic clk_i;
  logic rst_ni;
  logic rnddummy_en;
  freq_t dummy_freq;
  logic [2:0] seed_we;
  word_t seed_wdata;
  logic if_valid;
  instr_t if_instr;
  logic if_ready;
  logic id_ready;
  logic id_valid;
  instr_t id_instr;
  logic id_dummy;
  word_t operand_a;
  word_t operand_b;
  counter_t mcycle;
  counter_t minstret;

  // Model state mirrors the unit after the most recent clock edge
  word_t m_lfsr [3] = '{`LFSR0_DEFAULT, `LFSR1_DEFAULT, `LFSR2_DEFAULT};
  word_t m_cnt = '0;
  logic m_valid = 1'b0;
  logic m_dummy = 1'b0;
  instr_t m_instr = '0;
  word_t m_opa = '0;
  word_t m_opb = '0;
  counter_t m_mcycle = '0;
  counter_t m_minstret = '0;
  instr_t fetch_q [$];
  int n_dummy = 0;
  int n_normal = 0;
  int cycle_cnt = 0;
  word_t rng_state = 32'd82242;

  dummy_insert_unit dut_i (
    .clk_i, .rst_ni, .rnddummy_en, .dummy_freq, .seed_we, .seed_wdata,
    .if_valid, .if_instr, .if_ready, .id_ready, .id_valid, .id_instr, .id_dummy,
    .operand_a, .operand_b, .mcycle, .minstret
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) report_failure($sformatf("mismatch at %0t: %s expected %b got %b",
                                              $time, name, exp, got));
  endtask

  task automatic compare_instr(input string name, input instr_t got, input instr_t exp);
    if (got !== exp) report_failure($sformatf("mismatch at %0t: %s expected %h got %h",
                                              $time, name, exp, got));
  endtask

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) report_failure($sformatf("mismatch at %0t: %s expected %h got %h",
                                              $time, name, exp, got));
  endtask

  task automatic compare_counter(input string name, input counter_t got, input counter_t exp);
    if (got !== exp) report_failure($sformatf("mismatch at %0t: %s expected %0d got %0d",
                                              $time, name, exp, got));
  endtask

  // Stimulus generator that steps its LFSR once per bit handed out
  function automatic word_t take_bits(input int n);
    word_t r;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      rng_state = {rng_state[30:0], rng_state[31] ^ rng_state[21] ^ rng_state[1] ^ rng_state[0]};
      r = {r[30:0], rng_state[0]};
    end
    return r;
  endfunction

  function automatic word_t gap_bound(input freq_t f);
    word_t b;
    if (f == 4'd0) b = 32'd4;
    else if (f == 4'd1) b = 32'd8;
    else if (f <= 4'd3) b = 32'd16;
    else if (f <= 4'd7) b = 32'd32;
    else b = 32'd64;
    return b;
  endfunction

  function automatic word_t advance_lfsr(input word_t v, input logic wr, input logic step,
                                         input word_t wdata, input word_t dflt);
    word_t nxt;
    nxt = v;
    if (wr) nxt = wdata;
    else if (step) nxt = {v[30:0], v[31] ^ v[21] ^ v[1] ^ v[0]};
    if ((wr || step) && nxt == '0) nxt = dflt;
    return nxt;
  endfunction

  // RV32 words with rd x0 and, for the branch, every immediate bit zero
  function automatic instr_t encode_dummy(input word_t l0);
    instr_t w;
    reg_addr_t rs1;
    reg_addr_t rs2;
    rs1 = l0[29:25];
    rs2 = l0[24:20];
    case (l0[31:30])
      2'd0: w = {7'b0000000, rs2, rs1, 3'b000, 5'd0, 7'b0110011};
      2'd1: w = {7'b0000000, rs2, rs1, 3'b111, 5'd0, 7'b0110011};
      2'd2: w = {7'b0000001, rs2, rs1, 3'b000, 5'd0, 7'b0110011};
      default: w = {7'b0000000, rs2, rs1, 3'b110, 5'd0, 7'b1100011};
    endcase
    return w;
  endfunction

  // Runs between edges, so the inputs and the outputs are both settled
  task automatic check_and_step();
    word_t target;
    logic due;
    logic free;
    logic load_d;
    logic acc;
    logic leave;
    logic ret_dummy;
    target = m_lfsr[0] & (gap_bound(dummy_freq) - 32'd1);
    due = rnddummy_en && (m_cnt >= target);
    free = !m_valid || id_ready;
    load_d = free && due;
    acc = if_valid && free && !due;
    leave = m_valid && id_ready;
    ret_dummy = leave && m_dummy;
    compare_flag("if_ready", if_ready, free && !due);
    compare_flag("id_valid", id_valid, m_valid);
    compare_flag("id_dummy", id_dummy, m_dummy);
    compare_counter("mcycle", mcycle, m_mcycle);
    compare_counter("minstret", minstret, m_minstret);
    if (m_valid) begin
      // Normal instructions come from the fetch queue in order
      compare_instr("id_instr", id_instr, m_dummy ? m_instr : fetch_q[0]);
      compare_word("operand_a", operand_a, m_opa);
      compare_word("operand_b", operand_b, m_opb);
    end
    if (acc) fetch_q.push_back(if_instr);
    if (leave && !m_dummy) begin
      void'(fetch_q.pop_front());
      n_normal++;
      m_minstret = m_minstret + 64'd1;
    end
    if (ret_dummy) n_dummy++;
    m_mcycle = m_mcycle + 64'd1;
    if (free) begin
      if (load_d) begin
        m_instr = encode_dummy(m_lfsr[0]);
        m_opa = m_lfsr[1];
        m_opb = m_lfsr[2];
      end else if (acc) begin
        m_opa = '0;
        m_opb = '0;
      end
      m_valid = load_d || acc;
      m_dummy = load_d;
    end
    if (!rnddummy_en || load_d) m_cnt = '0;
    else if (acc) m_cnt = m_cnt + 32'd1;
    m_lfsr[0] = advance_lfsr(m_lfsr[0], seed_we[0], load_d, seed_wdata, `LFSR0_DEFAULT);
    m_lfsr[1] = advance_lfsr(m_lfsr[1], seed_we[1], ret_dummy, seed_wdata, `LFSR1_DEFAULT);
    m_lfsr[2] = advance_lfsr(m_lfsr[2], seed_we[2], ret_dummy, seed_wdata, `LFSR2_DEFAULT);
  endtask

  // Dummies are on in every phase after EN_START except phase 3
  task automatic drive_inputs(input int cyc);
    word_t sel;
    if (cyc >= EN_START && (cyc - EN_START) % PHASE_LEN == 0) begin
      rnddummy_en <= ((cyc - EN_START) / PHASE_LEN) != 3;
      dummy_freq <= freq_t'(take_bits(4));
    end
    if_valid <= take_bits(2) != 32'd0;
    if_instr <= take_bits(32);
    id_ready <= take_bits(2) != 32'd0;
    if (take_bits(5) == 32'd0) begin
      sel = take_bits(2);
      seed_we <= (sel == 32'd0) ? 3'b001 : (sel == 32'd1) ? 3'b010 : 3'b100;
      seed_wdata <= (take_bits(2) == 32'd0) ? '0 : take_bits(32);
    end else begin
      seed_we <= 3'b000;
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) report_failure("run exceeded its cycle limit");
  end

  initial begin
    rst_ni = 1'b0;
    rnddummy_en = 1'b0;
    dummy_freq = '0;
    seed_we = 3'b000;
    seed_wdata = '0;
    if_valid = 1'b0;
    if_instr = '0;
    id_ready = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int cyc = 0; cyc < TOTAL_CYCLES; cyc++) begin
      @(negedge clk_i);
      check_and_step();
      @(posedge clk_i);
      drive_inputs(cyc);
    end
    if (n_dummy == 0 || n_normal == 0) begin
      report_failure("run ended without both dummy and normal instructions leaving ID");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// ==== list.f ====
+incdir+.
dummy_pkg.sv
lfsr_state_if.sv
dummy_lfsr.sv
lfsr_bank.sv
dummy_scheduler.sv
dummy_encoder.sv
id_issue_stage.sv
perf_counters.sv
dummy_insert_unit.sv
dummy_insert_sva.sv
tb_dummy_insert.sv

// ==== Makefile ====
TOP := tb_dummy_insert

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert -f list.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
